//--- include/pwr_irq_macros.svh
// ============================
// power and interrupt control
// sizes and vector bit positions
// ============================

`ifndef PWR_IRQ_MACROS_SVH
`define PWR_IRQ_MACROS_SVH

// power domains
// cpu 0, peripheral 1, memory 2, external 3
`define PWR_NUM_DOMAINS 4
`define CPU_DOMAIN 0

// core interrupt vector
`define IRQ_WIDTH 32

// fast lines, top line always tied low
`define FAST_IRQ_NUM 15

// fixed level interrupt positions
`define IRQ_SOFTWARE_BIT 3
`define IRQ_TIMER_BIT 7
`define IRQ_EXTERNAL_BIT 11

// fast field starts here
`define IRQ_FAST_LSB 16

`endif

//--- logic/irq_collector.sv
// ============================
// fast interrupt pending bits
// and core vector assembly
// ============================

`timescale 1ns/100ps
`default_nettype none

`include "pwr_irq_macros.svh"

module irq_collector (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  irq_software_i,
  input  logic                  irq_external_i,
  input  logic [3:0]            timer_intr_i,
  input  logic                  dma_done_i,
  input  logic                  spi_intr_i,
  input  logic                  spi_flash_intr_i,
  input  logic [7:0]            gpio_intr_i,
  input  pwr_irq_pkg::fast_irq_t fast_clear_i,
  output pwr_irq_pkg::irq_vec_t  irq_vec_o,
  output logic                  any_pending_o
);

  import pwr_irq_pkg::*;

  fast_irq_t fast_src;
  fast_irq_t pending_q;

  // timer 0 is a level interrupt, timers 1-3 go fast
  assign fast_src = {
    1'b0,
    gpio_intr_i,
    spi_flash_intr_i,
    spi_intr_i,
    dma_done_i,
    timer_intr_i[3:1]
  };

  // set wins over clear
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pending_q <= '0;
    end else begin
      pending_q <= (pending_q & ~fast_clear_i) | fast_src;
    end
  end

  always_comb begin
    irq_vec_o = '0;
    irq_vec_o[`IRQ_SOFTWARE_BIT] = irq_software_i;
    irq_vec_o[`IRQ_TIMER_BIT] = timer_intr_i[0];
    irq_vec_o[`IRQ_EXTERNAL_BIT] = irq_external_i;
    irq_vec_o[`IRQ_FAST_LSB +: `FAST_IRQ_NUM] = pending_q;
  end

  assign any_pending_o = |irq_vec_o;

endmodule

`default_nettype wire

//--- logic/power_domain_seq.sv
// ============================
// power switching FSM for
// one domain
// ============================

`timescale 1ns/100ps
`default_nettype none

module power_domain_seq (
  input  logic    clk_i,
  input  logic    reset_i,
  input  logic    pwr_off_req_i,
  input  logic    pwr_on_req_i,
  pwr_ctrl_if.seq ctrl
);

  import pwr_irq_pkg::*;

  pwr_state_e state_q;
  pwr_state_e state_d;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= ON;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      // requests only count in the two stable states
      ON: begin
        if (pwr_off_req_i) begin
          state_d = CLK_OFF;
        end
      end
      CLK_OFF: state_d = ISO_ON;
      ISO_ON: state_d = RST_ON;
      RST_ON: state_d = SW_OFF;
      // switch may already report off
      SW_OFF: state_d = ctrl.pwrgate_ack_n ? WAIT_OFF : OFF;
      WAIT_OFF: begin
        if (!ctrl.pwrgate_ack_n) begin
          state_d = OFF;
        end
      end
      OFF: begin
        if (pwr_on_req_i) begin
          state_d = SW_ON;
        end
      end
      SW_ON: state_d = ctrl.pwrgate_ack_n ? RST_OFF : WAIT_ON;
      WAIT_ON: begin
        if (ctrl.pwrgate_ack_n) begin
          state_d = RST_OFF;
        end
      end
      RST_OFF: state_d = ISO_OFF;
      ISO_OFF: state_d = CLK_ON;
      CLK_ON: state_d = ON;
      default: state_d = ON;
    endcase
  end

  // controls decoded straight from the state register
  // clock runs only when fully on or re-enabled at the end of power-up
  assign ctrl.clkgate_en_n = state_q inside {ON, CLK_ON};

  assign ctrl.isogate_en_n = state_q inside {ON, CLK_OFF, ISO_OFF, CLK_ON};

  assign ctrl.rst_n = state_q inside {ON, CLK_OFF, ISO_ON, RST_OFF, ISO_OFF, CLK_ON};

  // switch open from SW_OFF until the on request
  assign ctrl.pwrgate_en_n = !(state_q inside {SW_OFF, WAIT_OFF, OFF});

  assign ctrl.domain_on = state_q inside {ON, CLK_OFF, ISO_ON, RST_ON, SW_OFF, WAIT_OFF};

endmodule

`default_nettype wire

//--- logic/pwr_ctrl_if.sv
// ============================
// per-domain power control
// ============================

`timescale 1ns/100ps
`default_nettype none

interface pwr_ctrl_if;

  // all active low except domain_on
  logic pwrgate_en_n;
  logic pwrgate_ack_n;
  logic isogate_en_n;
  logic rst_n;
  logic clkgate_en_n;
  logic domain_on;

  modport seq (
    output pwrgate_en_n,
    input  pwrgate_ack_n,
    output isogate_en_n,
    output rst_n,
    output clkgate_en_n,
    output domain_on
  );

  // reset combining only needs these
  modport gate (
    input rst_n,
    input domain_on
  );

endinterface

`default_nettype wire

//--- logic/pwr_irq_ctrl.sv
// ============================
// power and interrupt control
// top level
// ============================

`timescale 1ns/100ps
`default_nettype none

`include "pwr_irq_macros.svh"

module pwr_irq_ctrl (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     ndm_reset_i,

  input  pwr_irq_pkg::domain_vec_t pwr_off_req_i,
  input  pwr_irq_pkg::domain_vec_t pwr_on_req_i,
  input  pwr_irq_pkg::domain_vec_t pwrgate_ack_n_i,
  output pwr_irq_pkg::domain_vec_t pwrgate_en_n_o,
  output pwr_irq_pkg::domain_vec_t isogate_en_n_o,
  output pwr_irq_pkg::domain_vec_t clkgate_en_n_o,
  output pwr_irq_pkg::domain_vec_t subsys_rst_n_o,
  output pwr_irq_pkg::domain_vec_t domain_on_o,

  input  logic                     irq_software_i,
  input  logic                     irq_external_i,
  input  logic [3:0]               timer_intr_i,
  input  logic                     dma_done_i,
  input  logic                     spi_intr_i,
  input  logic                     spi_flash_intr_i,
  input  logic [7:0]               gpio_intr_i,
  input  pwr_irq_pkg::fast_irq_t   fast_clear_i,

  output pwr_irq_pkg::irq_vec_t    cpu_irq_o,
  output logic                     cpu_wake_o
);

  import pwr_irq_pkg::*;

  irq_vec_t irq_vec;
  logic     any_pending;

  pwr_ctrl_if dom_if [`PWR_NUM_DOMAINS-1:0] ();

  // one sequencer per domain, switch signals exposed at the top
  for (genvar i = 0; i < `PWR_NUM_DOMAINS; i++) begin : g_domain
    assign dom_if[i].pwrgate_ack_n = pwrgate_ack_n_i[i];

    assign pwrgate_en_n_o[i] = dom_if[i].pwrgate_en_n;
    assign isogate_en_n_o[i] = dom_if[i].isogate_en_n;
    assign clkgate_en_n_o[i] = dom_if[i].clkgate_en_n;
    assign domain_on_o[i]    = dom_if[i].domain_on;

    power_domain_seq u_seq (
      .clk_i         (clk_i),
      .reset_i       (reset_i),
      .pwr_off_req_i (pwr_off_req_i[i]),
      .pwr_on_req_i  (pwr_on_req_i[i]),
      .ctrl          (dom_if[i].seq)
    );
  end

  irq_collector u_irq_collector (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .irq_software_i   (irq_software_i),
    .irq_external_i   (irq_external_i),
    .timer_intr_i     (timer_intr_i),
    .dma_done_i       (dma_done_i),
    .spi_intr_i       (spi_intr_i),
    .spi_flash_intr_i (spi_flash_intr_i),
    .gpio_intr_i      (gpio_intr_i),
    .fast_clear_i     (fast_clear_i),
    .irq_vec_o        (irq_vec),
    .any_pending_o    (any_pending)
  );

  reset_irq_gate u_reset_irq_gate (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .ndm_reset_i    (ndm_reset_i),
    .dom            (dom_if),
    .irq_vec_i      (irq_vec),
    .any_pending_i  (any_pending),
    .subsys_rst_n_o (subsys_rst_n_o),
    .cpu_irq_o      (cpu_irq_o),
    .cpu_wake_o     (cpu_wake_o)
  );

endmodule

`default_nettype wire

//--- logic/pwr_irq_pkg.sv
// ============================
// vector types and power
// sequencer state encoding
// ============================

`default_nettype none

`include "pwr_irq_macros.svh"

package pwr_irq_pkg;

  typedef logic [`IRQ_WIDTH-1:0] irq_vec_t;
  typedef logic [`FAST_IRQ_NUM-1:0] fast_irq_t;
  typedef logic [`PWR_NUM_DOMAINS-1:0] domain_vec_t;

  // power-down runs top to bottom, power-up continues from SW_ON
  typedef enum logic [3:0] {
    ON,
    CLK_OFF,
    ISO_ON,
    RST_ON,
    SW_OFF,
    WAIT_OFF,
    OFF,
    SW_ON,
    WAIT_ON,
    RST_OFF,
    ISO_OFF,
    CLK_ON
  } pwr_state_e;

endpackage

`default_nettype wire

//--- logic/reset_irq_gate.sv
// ============================
// subsystem resets, cpu irq
// gating and wake request
// ============================

`timescale 1ns/100ps
`default_nettype none

`include "pwr_irq_macros.svh"

module reset_irq_gate (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     ndm_reset_i,
  pwr_ctrl_if.gate                 dom [`PWR_NUM_DOMAINS-1:0],
  input  pwr_irq_pkg::irq_vec_t    irq_vec_i,
  input  logic                     any_pending_i,
  output pwr_irq_pkg::domain_vec_t subsys_rst_n_o,
  output pwr_irq_pkg::irq_vec_t    cpu_irq_o,
  output logic                     cpu_wake_o
);

  import pwr_irq_pkg::*;

  domain_vec_t dom_rst_n;
  logic        cpu_on;

  for (genvar i = 0; i < `PWR_NUM_DOMAINS; i++) begin : g_dom
    assign dom_rst_n[i] = dom[i].rst_n;
  end

  assign cpu_on = dom[`CPU_DOMAIN].domain_on;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      subsys_rst_n_o <= '0;
      cpu_irq_o      <= '0;
      cpu_wake_o     <= 1'b0;
    end else begin
      // debug reset hits every domain but leaves power alone
      subsys_rst_n_o <= ndm_reset_i ? '0 : dom_rst_n;
      // nothing reaches a core that is powered down
      cpu_irq_o      <= cpu_on ? irq_vec_i : '0;
      // pending work while the core is off asks for power
      cpu_wake_o     <= !cpu_on && any_pending_i;
    end
  end

endmodule

`default_nettype wire

//--- pwr_irq_ctrl.f
+incdir+include
logic/pwr_irq_pkg.sv
logic/pwr_ctrl_if.sv
logic/power_domain_seq.sv
logic/irq_collector.sv
logic/reset_irq_gate.sv
logic/pwr_irq_ctrl.sv
test/tb_pwr_irq_ctrl.sv

//--- test/tb_pwr_irq_ctrl.sv
// ==============================
// testbench with clock, switch ack
// model, checks and directed tests
// ==============================

`timescale 1ns/100ps
`default_nettype none

`include "pwr_irq_macros.svh"

module tb_pwr_irq_ctrl;

  import pwr_irq_pkg::*;

  localparam int MAX_CYCLES     = 2000;
  localparam int ACK_WAIT_LIMIT = 40;

  logic        clk_i;
  logic        reset_i;
  logic        ndm_reset_i;
  domain_vec_t pwr_off_req_i;
  domain_vec_t pwr_on_req_i;
  domain_vec_t pwrgate_ack_n_i;
  domain_vec_t pwrgate_en_n_o;
  domain_vec_t isogate_en_n_o;
  domain_vec_t clkgate_en_n_o;
  domain_vec_t subsys_rst_n_o;
  domain_vec_t domain_on_o;
  logic        irq_software_i;
  logic        irq_external_i;
  logic [3:0]  timer_intr_i;
  logic        dma_done_i;
  logic        spi_intr_i;
  logic        spi_flash_intr_i;
  logic [7:0]  gpio_intr_i;
  fast_irq_t   fast_clear_i;
  irq_vec_t    cpu_irq_o;
  logic        cpu_wake_o;

  integer seed        = 32'h47757342;
  int     error_count = 0;
  int     check_count = 0;
  int     cycle_count = 0;
  int     ack_count [`PWR_NUM_DOMAINS];
  int     ack_delay [`PWR_NUM_DOMAINS];

  pwr_irq_ctrl dut (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .ndm_reset_i      (ndm_reset_i),
    .pwr_off_req_i    (pwr_off_req_i),
    .pwr_on_req_i     (pwr_on_req_i),
    .pwrgate_ack_n_i  (pwrgate_ack_n_i),
    .pwrgate_en_n_o   (pwrgate_en_n_o),
    .isogate_en_n_o   (isogate_en_n_o),
    .clkgate_en_n_o   (clkgate_en_n_o),
    .subsys_rst_n_o   (subsys_rst_n_o),
    .domain_on_o      (domain_on_o),
    .irq_software_i   (irq_software_i),
    .irq_external_i   (irq_external_i),
    .timer_intr_i     (timer_intr_i),
    .dma_done_i       (dma_done_i),
    .spi_intr_i       (spi_intr_i),
    .spi_flash_intr_i (spi_flash_intr_i),
    .gpio_intr_i      (gpio_intr_i),
    .fast_clear_i     (fast_clear_i),
    .cpu_irq_o        (cpu_irq_o),
    .cpu_wake_o       (cpu_wake_o)
  );

  always #20 clk_i = ~clk_i;

  function automatic int next_ack_delay();
    return ($unsigned($random(seed)) % 16) + 1;
  endfunction

  // power switch model whose ack follows the enable after a random delay
  always @(negedge clk_i) begin
    for (int d = 0; d < `PWR_NUM_DOMAINS; d++) begin
      if (pwrgate_ack_n_i[d] != pwrgate_en_n_o[d]) begin
        if (ack_count[d] >= ack_delay[d]) begin
          pwrgate_ack_n_i[d] <= pwrgate_en_n_o[d];
          ack_count[d] = 0;
          ack_delay[d] = next_ack_delay();
        end else begin
          ack_count[d] = ack_count[d] + 1;
        end
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("timeout: run still busy after %0d cycles, %0d checks, %0d errors",
               MAX_CYCLES, check_count, error_count);
      $display("Test failed");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("Fail at %0t: %s is %h, expected %h", $time, name, actual, expected);
    end
  endtask

  // all domains on except one that takes the given level
  function automatic domain_vec_t domain_pattern(input int dom, input logic v);
    domain_vec_t p;
    p = '1;
    p[dom] = v;
    return p;
  endfunction

  task automatic check_domains(input int dom, input logic pwr, input logic iso,
                               input logic clk, input logic rst, input logic on);
    check_value("pwrgate_en_n_o", pwrgate_en_n_o, domain_pattern(dom, pwr));
    check_value("isogate_en_n_o", isogate_en_n_o, domain_pattern(dom, iso));
    check_value("clkgate_en_n_o", clkgate_en_n_o, domain_pattern(dom, clk));
    check_value("subsys_rst_n_o", subsys_rst_n_o, domain_pattern(dom, rst));
    check_value("domain_on_o", domain_on_o, domain_pattern(dom, on));
  endtask

  // fast index order is timer 1-3, dma, spi, spi flash then gpio 0-7
  task automatic set_fast_source(input int idx, input logic v);
    if (idx < 3) begin
      timer_intr_i[idx + 1] = v;
    end else if (idx == 3) begin
      dma_done_i = v;
    end else if (idx == 4) begin
      spi_intr_i = v;
    end else if (idx == 5) begin
      spi_flash_intr_i = v;
    end else begin
      gpio_intr_i[idx - 6] = v;
    end
  endtask

  function automatic irq_vec_t fast_bit(input int idx);
    return irq_vec_t'(1) << (`IRQ_FAST_LSB + idx);
  endfunction

  task automatic power_down(input int dom);
    int waited;
    waited = 0;
    pwr_off_req_i[dom] = 1'b1;
    @(negedge clk_i);
    pwr_off_req_i[dom] = 1'b0;
    check_domains(dom, 1'b1, 1'b1, 1'b0, 1'b1, 1'b1);
    @(negedge clk_i);
    check_domains(dom, 1'b1, 1'b0, 1'b0, 1'b1, 1'b1);
    // domain reset is low now and the subsystem reset follows a cycle later
    @(negedge clk_i);
    check_domains(dom, 1'b1, 1'b0, 1'b0, 1'b1, 1'b1);
    @(negedge clk_i);
    check_domains(dom, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
    do begin
      @(negedge clk_i);
      waited++;
      check_domains(dom, 1'b0, 1'b0, 1'b0, 1'b0, pwrgate_ack_n_i[dom]);
    end while (pwrgate_ack_n_i[dom] && waited < ACK_WAIT_LIMIT);
    if (pwrgate_ack_n_i[dom]) begin
      error_count++;
      $display("switch acknowledge of domain %0d never went low", dom);
    end
  endtask

  task automatic power_up(input int dom);
    int waited;
    waited = 0;
    pwr_on_req_i[dom] = 1'b1;
    do begin
      @(negedge clk_i);
      pwr_on_req_i[dom] = 1'b0;
      waited++;
      check_domains(dom, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
    end while (!pwrgate_ack_n_i[dom] && waited < ACK_WAIT_LIMIT);
    if (!pwrgate_ack_n_i[dom]) begin
      error_count++;
      $display("switch acknowledge of domain %0d never went high", dom);
    end
    @(negedge clk_i);
    check_domains(dom, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0);
    @(negedge clk_i);
    check_domains(dom, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0);
    @(negedge clk_i);
    check_domains(dom, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1);
  endtask

  task automatic test_reset_state();
    check_value("subsys_rst_n_o", subsys_rst_n_o, '0);
    @(negedge clk_i);
    check_domains(0, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1);
    check_value("cpu_irq_o", cpu_irq_o, '0);
    check_value("cpu_wake_o", cpu_wake_o, 1'b0);
  endtask

  task automatic test_peripheral_cycle();
    power_down(1);
    repeat (3) begin
      @(negedge clk_i);
      check_domains(1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    end
    power_up(1);
  endtask

  task automatic test_vector_mapping();
    irq_software_i = 1'b1;
    @(negedge clk_i);
    check_value("cpu_irq_o", cpu_irq_o, irq_vec_t'(1) << `IRQ_SOFTWARE_BIT);
    irq_software_i = 1'b0;
    timer_intr_i[0] = 1'b1;
    @(negedge clk_i);
    check_value("cpu_irq_o", cpu_irq_o, irq_vec_t'(1) << `IRQ_TIMER_BIT);
    timer_intr_i[0] = 1'b0;
    irq_external_i = 1'b1;
    @(negedge clk_i);
    check_value("cpu_irq_o", cpu_irq_o, irq_vec_t'(1) << `IRQ_EXTERNAL_BIT);
    irq_external_i = 1'b0;
    @(negedge clk_i);
    check_value("cpu_irq_o", cpu_irq_o, '0);
    for (int i = 0; i < `FAST_IRQ_NUM - 1; i++) begin
      set_fast_source(i, 1'b1);
      @(negedge clk_i);
      check_value("cpu_irq_o", cpu_irq_o, '0);
      set_fast_source(i, 1'b0);
      @(negedge clk_i);
      check_value("cpu_irq_o", cpu_irq_o, fast_bit(i));
      fast_clear_i[i] = 1'b1;
      @(negedge clk_i);
      check_value("cpu_irq_o", cpu_irq_o, fast_bit(i));
      fast_clear_i[i] = 1'b0;
      @(negedge clk_i);
      check_value("cpu_irq_o", cpu_irq_o, '0);
    end
    // every source at once leaves the unused fast line and bit 31 low
    for (int i = 0; i < `FAST_IRQ_NUM - 1; i++) begin
      set_fast_source(i, 1'b1);
    end
    @(negedge clk_i);
    for (int i = 0; i < `FAST_IRQ_NUM - 1; i++) begin
      set_fast_source(i, 1'b0);
    end
    fast_clear_i = '1;
    @(negedge clk_i);
    check_value("cpu_irq_o", cpu_irq_o, 32'h3fff_0000);
    fast_clear_i = '0;
    @(negedge clk_i);
    check_value("cpu_irq_o", cpu_irq_o, '0);
  endtask

  task automatic test_pending_clear();
    set_fast_source(8, 1'b1);
    @(negedge clk_i);
    set_fast_source(8, 1'b0);
    repeat (4) begin
      @(negedge clk_i);
      check_value("cpu_irq_o", cpu_irq_o, fast_bit(8));
    end
    fast_clear_i[8] = 1'b1;
    @(negedge clk_i);
    fast_clear_i[8] = 1'b0;
    @(negedge clk_i);
    check_value("cpu_irq_o", cpu_irq_o, '0);
    // set wins when set and clear come together
    set_fast_source(4, 1'b1);
    fast_clear_i[4] = 1'b1;
    @(negedge clk_i);
    set_fast_source(4, 1'b0);
    fast_clear_i[4] = 1'b0;
    repeat (2) begin
      @(negedge clk_i);
      check_value("cpu_irq_o", cpu_irq_o, fast_bit(4));
    end
    fast_clear_i[4] = 1'b1;
    @(negedge clk_i);
    fast_clear_i[4] = 1'b0;
    @(negedge clk_i);
    check_value("cpu_irq_o", cpu_irq_o, '0);
  endtask

  task automatic test_cpu_off();
    power_down(`CPU_DOMAIN);
    check_value("cpu_wake_o", cpu_wake_o, 1'b0);
    set_fast_source(3, 1'b1);
    @(negedge clk_i);
    set_fast_source(3, 1'b0);
    check_value("cpu_wake_o", cpu_wake_o, 1'b0);
    @(negedge clk_i);
    check_value("cpu_wake_o", cpu_wake_o, 1'b1);
    check_value("cpu_irq_o", cpu_irq_o, '0);
    power_up(`CPU_DOMAIN);
    check_value("cpu_irq_o", cpu_irq_o, '0);
    @(negedge clk_i);
    check_value("cpu_irq_o", cpu_irq_o, fast_bit(3));
    check_value("cpu_wake_o", cpu_wake_o, 1'b0);
    fast_clear_i[3] = 1'b1;
    @(negedge clk_i);
    fast_clear_i[3] = 1'b0;
    @(negedge clk_i);
    check_value("cpu_irq_o", cpu_irq_o, '0);
  endtask

  task automatic test_debug_reset();
    // external domain stays off across the debug reset
    power_down(3);
    ndm_reset_i = 1'b1;
    repeat (2) begin
      @(negedge clk_i);
      check_value("subsys_rst_n_o", subsys_rst_n_o, '0);
      check_value("pwrgate_en_n_o", pwrgate_en_n_o, domain_pattern(3, 1'b0));
      check_value("isogate_en_n_o", isogate_en_n_o, domain_pattern(3, 1'b0));
      check_value("clkgate_en_n_o", clkgate_en_n_o, domain_pattern(3, 1'b0));
      check_value("domain_on_o", domain_on_o, domain_pattern(3, 1'b0));
    end
    ndm_reset_i = 1'b0;
    @(negedge clk_i);
    check_domains(3, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    power_up(3);
  endtask

  initial begin
    clk_i            = 1'b0;
    reset_i          = 1'b1;
    ndm_reset_i      = 1'b0;
    pwr_off_req_i    = '0;
    pwr_on_req_i     = '0;
    pwrgate_ack_n_i  = '1;
    irq_software_i   = 1'b0;
    irq_external_i   = 1'b0;
    timer_intr_i     = '0;
    dma_done_i       = 1'b0;
    spi_intr_i       = 1'b0;
    spi_flash_intr_i = 1'b0;
    gpio_intr_i      = '0;
    fast_clear_i     = '0;
    for (int d = 0; d < `PWR_NUM_DOMAINS; d++) begin
      ack_count[d] = 0;
      ack_delay[d] = next_ack_delay();
    end
    repeat (3) @(negedge clk_i);
    reset_i = 1'b0;
    test_reset_state();
    test_peripheral_cycle();
    test_vector_mapping();
    test_pending_clear();
    test_cpu_off();
    test_debug_reset();
    $display("%0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
